/* all.f */
logic/camera_ctrl_pkg.sv
logic/board_housekeeping.sv
logic/camera_bringup_sequencer.sv
logic/camera_ctrl_top.sv
verification/tb_clock_gen.sv
verification/camera_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the camera control simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module camera_ctrl_tb -f all.f -o camera_ctrl_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/camera_ctrl_sim; then
    echo "Simulation reported a failure"
    exit 1
fi

exit 0

/* verification/camera_ctrl_tb.sv */
// Table-driven testbench that walks the camera control top level through bring-up and refresh
module camera_ctrl_tb;

    localparam int unsigned long_count = 20;
    localparam int unsigned heartbeat_low = 2;
    localparam int unsigned heartbeat_high = 4;
    localparam int unsigned clock_period = 4;
    localparam int unsigned reset_cycles = 10;
    localparam int unsigned watchdog_margin = 200;

    // Timer expires long_count+1 cycles after a load
    localparam int unsigned expiry_cycles = long_count + 1;
    // Held refresh button gives one pulse per expiry plus the registered cycle
    localparam int unsigned refresh_period = long_count + 2;
    localparam int unsigned heartbeat_period = 1 << (heartbeat_high + 1);
    localparam int unsigned heartbeat_on = 1 << heartbeat_low;

    // Status columns lcd_running lcd_busy camera_idle camera_busy camera_error image_transfer
    localparam logic [5:0] all_quiet = 6'b000000;
    localparam logic [5:0] lcd_down_cam_idle = 6'b001000;
    localparam logic [5:0] cam_busy = 6'b101100;
    localparam logic [5:0] cam_error = 6'b100010;
    localparam logic [5:0] all_ready = 6'b101000;
    localparam logic [5:0] lcd_busy_set = 6'b111000;
    localparam logic [5:0] transfer_set = 6'b101001;

    // Button columns retry pause refresh reload
    // All buttons active low
    localparam logic [3:0] no_button = 4'b1111;
    localparam logic [3:0] retry_held = 4'b0111;
    localparam logic [3:0] pause_held = 4'b1011;
    localparam logic [3:0] refresh_held = 4'b1101;
    localparam logic [3:0] reload_held = 4'b1110;

    typedef struct packed {
        logic [5:0] status;
        logic [3:0] buttons;
        int unsigned cycles;
        camera_ctrl_pkg::control_state_t shown_state;
        logic start;
        logic programn;
        int unsigned refresh_pulses;
        int unsigned configure_pulses;
    } row_t;

    row_t table_rows[$];
    string row_names[$];
    int unsigned total_cycles;
    int unsigned cycle_count;
    int unsigned refresh_seen;
    int unsigned configure_seen;
    logic table_ready;

    logic clock_48mhz;
    logic reset;
    logic retry_button;
    logic pause_button;
    logic refresh_button;
    logic reload_button;
    logic lcd_running;
    logic lcd_busy;
    logic camera_idle;
    logic camera_busy;
    logic camera_error;
    logic camera_image_transfer;
    logic camera_configure;
    logic camera_start;
    logic refresh;
    camera_ctrl_pkg::state_leds_t state_leds;
    logic heartbeat_led;
    logic camera_xclk;
    logic programn;

    tb_clock_gen #(
        .period(clock_period)
    ) clock_source (
        .clock_48mhz(clock_48mhz)
    );

    camera_ctrl_top #(
        .long_count(long_count),
        .heartbeat_low(heartbeat_low),
        .heartbeat_high(heartbeat_high)
    ) uut (
        .clock_48mhz(clock_48mhz),
        .reset(reset),
        .retry_button(retry_button),
        .pause_button(pause_button),
        .refresh_button(refresh_button),
        .reload_button(reload_button),
        .lcd_running(lcd_running),
        .lcd_busy(lcd_busy),
        .camera_idle(camera_idle),
        .camera_busy(camera_busy),
        .camera_error(camera_error),
        .camera_image_transfer(camera_image_transfer),
        .camera_configure(camera_configure),
        .camera_start(camera_start),
        .refresh(refresh),
        .state_leds(state_leds),
        .heartbeat_led(heartbeat_led),
        .camera_xclk(camera_xclk),
        .programn(programn)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_leds(input string name, input camera_ctrl_pkg::state_leds_t actual,
                                input camera_ctrl_pkg::state_leds_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] t=%0t %s: got %b, expected %b",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] t=%0t %s: got %b, expected %b",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic compare_count(input string name, input int unsigned actual,
                                 input int unsigned expected);
        if (actual != expected) begin
            stop_with_failure($sformatf("[FAIL] t=%0t %s: got %0d, expected %0d",
                                        $time, name, actual, expected));
        end
    endtask

    // LED bit 0 configuring, bit 1 running, bit 2 error
    function automatic camera_ctrl_pkg::state_leds_t leds_for_state(
        input camera_ctrl_pkg::control_state_t state
    );
        camera_ctrl_pkg::state_leds_t leds;
        leds = '0;
        case (state)
            camera_ctrl_pkg::configuring: leds[0] = 1'b1;
            camera_ctrl_pkg::running: leds[1] = 1'b1;
            camera_ctrl_pkg::error: leds[2] = 1'b1;
            default: leds = '0;
        endcase
        return leds;
    endfunction

    task automatic add_row(input string name, input logic [5:0] status, input logic [3:0] buttons,
                           input int unsigned cycles,
                           input camera_ctrl_pkg::control_state_t shown_state,
                           input logic start, input logic programn_level,
                           input int unsigned refresh_pulses, input int unsigned configure_pulses);
        row_t row;
        row.status = status;
        row.buttons = buttons;
        row.cycles = cycles;
        row.shown_state = shown_state;
        row.start = start;
        row.programn = programn_level;
        row.refresh_pulses = refresh_pulses;
        row.configure_pulses = configure_pulses;
        table_rows.push_back(row);
        row_names.push_back(name);
        total_cycles += cycles;
    endtask

    task automatic apply_inputs(input row_t row);
        {lcd_running, lcd_busy, camera_idle, camera_busy, camera_error,
         camera_image_transfer} = row.status;
        {retry_button, pause_button, refresh_button, reload_button} = row.buttons;
    endtask

    // Divider and heartbeat follow the number of clock edges since reset release
    task automatic check_housekeeping();
        compare_bit("camera_xclk", camera_xclk, cycle_count[0]);
        compare_bit("heartbeat_led", heartbeat_led,
                    (cycle_count % heartbeat_period) < heartbeat_on);
    endtask

    task automatic build_table();
        add_row("power-up wait", all_quiet, no_button, expiry_cycles,
                camera_ctrl_pkg::power_down, 1'b0, 1'b1, 0, 0);
        add_row("configure pulse", all_quiet, no_button, 1,
                camera_ctrl_pkg::power_down, 1'b0, 1'b1, 0, 1);
        add_row("lcd not running", lcd_down_cam_idle, no_button, 10,
                camera_ctrl_pkg::configuring, 1'b0, 1'b1, 0, 0);
        add_row("camera busy", cam_busy, no_button, 10,
                camera_ctrl_pkg::configuring, 1'b0, 1'b1, 0, 0);
        add_row("camera error", cam_error, no_button, 2,
                camera_ctrl_pkg::error, 1'b0, 1'b1, 0, 0);
        // Retry is ignored until the hold-off timer has expired
        add_row("retry in hold-off", all_quiet, retry_held, long_count,
                camera_ctrl_pkg::error, 1'b0, 1'b1, 0, 0);
        add_row("retry accepted", all_quiet, retry_held, 1,
                camera_ctrl_pkg::error, 1'b0, 1'b1, 0, 0);
        add_row("second power-up", all_quiet, no_button, expiry_cycles + 1,
                camera_ctrl_pkg::power_down, 1'b0, 1'b1, 0, 1);
        add_row("camera ready", all_ready, no_button, 2,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 0, 0);
        add_row("refresh window", all_ready, refresh_held, 10 * refresh_period,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 10, 0);
        add_row("lcd busy gate", lcd_busy_set, refresh_held, 60,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 0, 0);
        add_row("camera busy gate", cam_busy, refresh_held, 30,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 0, 0);
        add_row("transfer gate", transfer_set, refresh_held, 30,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 0, 0);
        add_row("pause after expiry", all_ready, pause_held, 5,
                camera_ctrl_pkg::running, 1'b0, 1'b1, 0, 0);
        add_row("pause released", all_ready, no_button, 5,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 0, 0);
        add_row("single refresh", all_ready, refresh_held, 1,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 1, 0);
        add_row("pause while timer runs", all_ready, pause_held, long_count,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 0, 0);
        add_row("pause after hold-off", all_ready, pause_held, 2,
                camera_ctrl_pkg::running, 1'b0, 1'b1, 0, 0);
        add_row("pause released again", all_ready, no_button, 2,
                camera_ctrl_pkg::running, 1'b1, 1'b1, 0, 0);
        add_row("reload press", all_ready, reload_held, 1,
                camera_ctrl_pkg::running, 1'b1, 1'b0, 0, 0);
        add_row("reload released", all_ready, no_button, 10,
                camera_ctrl_pkg::running, 1'b1, 1'b0, 0, 0);
    endtask

    initial begin
        total_cycles = 0;
        cycle_count = 0;
        table_ready = 1'b0;
        reset = 1'b1;
        apply_inputs({all_quiet, no_button, 32'd0, camera_ctrl_pkg::power_down,
                      1'b0, 1'b1, 32'd0, 32'd0});
        build_table();
        table_ready = 1'b1;

        repeat (reset_cycles) begin
            @(posedge clock_48mhz);
            #1;
        end
        compare_leds("reset state_leds", state_leds, '0);
        compare_bit("reset camera_configure", camera_configure, 1'b0);
        compare_bit("reset camera_start", camera_start, 1'b0);
        compare_bit("reset refresh", refresh, 1'b0);
        compare_bit("reset programn", programn, 1'b1);
        check_housekeeping();
        reset = 1'b0;

        foreach (table_rows[i]) begin
            apply_inputs(table_rows[i]);
            refresh_seen = 0;
            configure_seen = 0;
            repeat (table_rows[i].cycles) begin
                @(posedge clock_48mhz);
                #1;
                cycle_count++;
                if (refresh) begin
                    refresh_seen++;
                end
                if (camera_configure) begin
                    configure_seen++;
                end
                check_housekeeping();
            end
            compare_leds($sformatf("%s state_leds", row_names[i]), state_leds,
                         leds_for_state(table_rows[i].shown_state));
            compare_bit($sformatf("%s camera_start", row_names[i]), camera_start,
                        table_rows[i].start);
            compare_bit($sformatf("%s programn", row_names[i]), programn,
                        table_rows[i].programn);
            compare_count($sformatf("%s refresh pulses", row_names[i]), refresh_seen,
                          table_rows[i].refresh_pulses);
            compare_count($sformatf("%s configure pulses", row_names[i]), configure_seen,
                          table_rows[i].configure_pulses);
        end

        $display("Test passed");
        $finish;
    end

    // Deadline covers reset plus every table row
    initial begin
        wait (table_ready);
        #((reset_cycles + total_cycles) * clock_period + watchdog_margin);
        stop_with_failure("Watchdog timeout, the table did not finish in the expected time");
    end

endmodule

/* verification/tb_clock_gen.sv */
// Free-running clock source that drives the camera control testbench
module tb_clock_gen #(
    parameter int unsigned period = 4
) (
    output logic clock_48mhz
);

    // Starts low so the first rising edge lands half a period in
    initial begin
        clock_48mhz = 1'b0;
        forever begin
            #(period / 2) clock_48mhz = ~clock_48mhz;
        end
    end

endmodule

/* logic/camera_ctrl_top.sv */
// Top level of the badge camera control that sets timing parameters and joins both blocks
module camera_ctrl_top #(
    parameter int unsigned long_count = camera_ctrl_pkg::default_long_count,
    parameter int unsigned heartbeat_low = camera_ctrl_pkg::default_heartbeat_low,
    parameter int unsigned heartbeat_high = camera_ctrl_pkg::default_heartbeat_high
) (
    input  logic clock_48mhz,
    input  logic reset,

    // Buttons, active low
    input  logic retry_button,
    input  logic pause_button,
    input  logic refresh_button,
    input  logic reload_button,

    // Status levels from the LCD and camera blocks
    input  logic lcd_running,
    input  logic lcd_busy,
    input  logic camera_idle,
    input  logic camera_busy,
    input  logic camera_error,
    input  logic camera_image_transfer,

    // Commands and indicators
    output logic camera_configure,
    output logic camera_start,
    output logic refresh,
    output camera_ctrl_pkg::state_leds_t state_leds,
    output logic heartbeat_led,
    output logic camera_xclk,
    output logic programn
);

    board_housekeeping #(
        .heartbeat_low(heartbeat_low),
        .heartbeat_high(heartbeat_high)
    ) housekeeping (
        .clock_48mhz(clock_48mhz),
        .reset(reset),
        .reload_button(reload_button),
        .programn(programn),
        .camera_xclk(camera_xclk),
        .heartbeat_led(heartbeat_led)
    );

    // Bring-up and refresh control
    camera_bringup_sequencer #(
        .long_count(long_count)
    ) sequencer (
        .clock_48mhz(clock_48mhz),
        .reset(reset),
        .retry_button(retry_button),
        .pause_button(pause_button),
        .refresh_button(refresh_button),
        .lcd_running(lcd_running),
        .lcd_busy(lcd_busy),
        .camera_idle(camera_idle),
        .camera_busy(camera_busy),
        .camera_error(camera_error),
        .camera_image_transfer(camera_image_transfer),
        .camera_configure(camera_configure),
        .camera_start(camera_start),
        .refresh(refresh),
        .state_leds(state_leds)
    );

endmodule

/* logic/camera_bringup_sequencer.sv */
// Camera and LCD bring-up FSM that issues camera commands and paced LCD refresh requests
module camera_bringup_sequencer #(
    parameter int unsigned long_count = 4194304
) (
    input  logic clock_48mhz,
    input  logic reset,
    input  logic retry_button,
    input  logic pause_button,
    input  logic refresh_button,
    input  logic lcd_running,
    input  logic lcd_busy,
    input  logic camera_idle,
    input  logic camera_busy,
    input  logic camera_error,
    input  logic camera_image_transfer,
    output logic camera_configure,
    output logic camera_start,
    output logic refresh,
    output camera_ctrl_pkg::state_leds_t state_leds
);

    localparam int unsigned timer_bits = camera_ctrl_pkg::timer_width + 1;

    // Reload value sized to the timer including its expiry bit
    localparam logic [camera_ctrl_pkg::timer_width:0] timer_reload =
        timer_bits'(long_count);

    camera_ctrl_pkg::control_state_t control_state;

    logic [camera_ctrl_pkg::timer_width:0] control_timer;
    logic timer_expired;
    logic system_idle;
    logic camera_ready;

    // Top bit sets when the count passes zero
    assign timer_expired = control_timer[camera_ctrl_pkg::timer_width];

    // Nothing in the image path may be moving when a refresh goes out
    assign system_idle = !camera_busy && !lcd_busy && !camera_image_transfer;

    assign camera_ready = camera_idle && !camera_busy;

    always_ff @(posedge clock_48mhz) begin
        if (reset) begin
            control_state <= camera_ctrl_pkg::power_down;
            control_timer <= timer_reload;
            camera_configure <= 1'b0;
            camera_start <= 1'b0;
            refresh <= 1'b0;
        end else begin
            // Strobes last a single cycle
            camera_configure <= 1'b0;
            refresh <= 1'b0;

            // Count down until expired, then hold
            if (!timer_expired) begin
                control_timer <= control_timer - 1'b1;
            end

            case (control_state)
                camera_ctrl_pkg::power_down: begin
                    // Give the camera time to power up before configuring
                    if (timer_expired) begin
                        camera_configure <= 1'b1;
                        control_state <= camera_ctrl_pkg::configuring;
                    end
                end

                camera_ctrl_pkg::configuring: begin
                    // No LCD means nothing useful can happen, so just wait
                    if (lcd_running) begin
                        if (camera_ready) begin
                            camera_start <= 1'b1;
                            control_timer <= timer_reload;
                            control_state <= camera_ctrl_pkg::running;
                        end else if (camera_error) begin
                            camera_start <= 1'b0;
                            control_timer <= timer_reload;
                            control_state <= camera_ctrl_pkg::error;
                        end
                    end
                end

                camera_ctrl_pkg::running: begin
                    // Timer paces refreshes and pause sampling
                    if (timer_expired) begin
                        if (!refresh_button && system_idle) begin
                            refresh <= 1'b1;
                            control_timer <= timer_reload;
                        end
                        // Pause button held low stops the camera
                        camera_start <= pause_button;
                    end
                end

                camera_ctrl_pkg::error: begin
                    // Retry only after the hold-off
                    if (timer_expired && !retry_button) begin
                        control_timer <= timer_reload;
                        control_state <= camera_ctrl_pkg::power_down;
                    end
                end

                default: begin
                    control_state <= camera_ctrl_pkg::power_down;
                    control_timer <= timer_reload;
                end
            endcase
        end
    end

    // State LEDs trail the state by one cycle
    always_ff @(posedge clock_48mhz) begin
        if (reset) begin
            state_leds <= camera_ctrl_pkg::leds_off;
        end else begin
            case (control_state)
                camera_ctrl_pkg::configuring: begin
                    state_leds <= camera_ctrl_pkg::leds_configuring;
                end
                camera_ctrl_pkg::running: begin
                    state_leds <= camera_ctrl_pkg::leds_running;
                end
                camera_ctrl_pkg::error: begin
                    state_leds <= camera_ctrl_pkg::leds_error;
                end
                default: begin
                    state_leds <= camera_ctrl_pkg::leds_off;
                end
            endcase
        end
    end

endmodule

/* logic/board_housekeeping.sv */
// Board support logic for FPGA reload request, camera clock and heartbeat LED
module board_housekeeping #(
    parameter int unsigned heartbeat_low = 19,
    parameter int unsigned heartbeat_high = 25
) (
    input  logic clock_48mhz,
    input  logic reset,
    input  logic reload_button,
    output logic programn,
    output logic camera_xclk,
    output logic heartbeat_led
);

    logic fpga_reload;
    logic xclk_toggle;
    logic [heartbeat_high:0] heartbeat_counter;

    // Reload request sticks once the button is seen low
    always_ff @(posedge clock_48mhz) begin
        if (reset) begin
            fpga_reload <= 1'b0;
        end else if (!reload_button) begin
            fpga_reload <= 1'b1;
        end
    end

    assign programn = !fpga_reload;

    // Half-rate camera clock, 24 MHz on the board
    always_ff @(posedge clock_48mhz) begin
        if (reset) begin
            xclk_toggle <= 1'b0;
        end else begin
            xclk_toggle <= !xclk_toggle;
        end
    end

    assign camera_xclk = xclk_toggle;

    // Free-running counter for the heartbeat
    always_ff @(posedge clock_48mhz) begin
        if (reset) begin
            heartbeat_counter <= '0;
        end else begin
            heartbeat_counter <= heartbeat_counter + 1'b1;
        end
    end

    // Short blink while the upper window of the counter is all zero
    assign heartbeat_led = (heartbeat_counter[heartbeat_high:heartbeat_low] == '0);

endmodule

/* logic/camera_ctrl_pkg.sv */
// Shared types and constants that the camera control modules and testbench reach by scoped name
package camera_ctrl_pkg;

    // Countdown width, the timer register carries one more bit for expiry
    localparam int unsigned timer_width = 24;

    // Reload value used in the board build
    localparam int unsigned default_long_count = 2 ** 22;

    // Heartbeat blink window inside the free-running counter
    localparam int unsigned default_heartbeat_low = 19;
    localparam int unsigned default_heartbeat_high = 25;

    // Bring-up states of the control FSM
    typedef enum logic [2:0] {
        power_down  = 3'd0,
        configuring = 3'd1,
        running     = 3'd2,
        error       = 3'd3
    } control_state_t;

    // One LED per active state
    typedef logic [2:0] state_leds_t;

    localparam state_leds_t leds_off = 3'b000;
    localparam state_leds_t leds_configuring = 3'b001;
    localparam state_leds_t leds_running = 3'b010;
    localparam state_leds_t leds_error = 3'b100;

endpackage
